// ==== verilog/fetch_pkg.sv ====
////////////////////
// fetch front end shared types
// fetch words, aligned instructions, aligner states and sizing
////////////////////

package fetch_pkg;

  ////////////////////
  // sizing
  ////////////////////

  // address and memory word width
  localparam int unsigned xlen = 32;
  // prefetch FIFO entries
  localparam int unsigned fifo_depth = 4;

  ////////////////////
  // payloads
  ////////////////////

  // one memory word and the word-aligned address it came from
  typedef struct packed {
    logic [xlen-1:0] data;
    logic [xlen-1:0] addr;
  } fetch_word_t;

  // one instruction toward decode
  // upper half is zero for a compressed instruction
  typedef struct packed {
    logic [31:0]     instr;
    logic            compressed;
    logic [xlen-1:0] pc;
  } instr_t;

  // aligner position relative to the word boundary
  typedef enum logic [2:0] {
    aligned32,
    aligned16,
    misaligned32,
    misaligned16,
    branch_misaligned
  } align_state_e;

endpackage

// ==== verilog/fetch_mem_port.sv ====
////////////////////
// fetch memory port
// four-phase req/ack master, pushes fetched words to the prefetch FIFO
////////////////////

`timescale 1ns/1ps

module fetch_mem_port (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       branch_i,
  input  logic [fetch_pkg::xlen-1:0] branch_addr_i,
  input  logic                       slot_free_i,
  output logic                       mem_req_o,
  output logic [fetch_pkg::xlen-1:0] mem_addr_o,
  input  logic                       mem_ack_i,
  input  logic [fetch_pkg::xlen-1:0] mem_rdata_i,
  output logic                       push_o,
  output fetch_pkg::fetch_word_t     push_data_o
);

  // idle: ack seen low, req may rise
  // req: req high, waiting for ack
  // release: req low, waiting for ack to fall
  typedef enum logic [1:0] {
    port_idle,
    port_req,
    port_release
  } port_state_e;

  port_state_e                 state_q;
  logic [fetch_pkg::xlen-1:0]  fetch_addr_q;
  logic [fetch_pkg::xlen-1:0]  req_addr_q;
  logic                        drop_q;
  logic                        start_req;
  logic                        ack_seen;

  // no new request in a branch cycle, target not loaded yet
  assign start_req = (state_q == port_idle) && slot_free_i && !branch_i;
  // first cycle of ack high
  assign ack_seen  = (state_q == port_req) && mem_ack_i;

  assign mem_req_o  = (state_q == port_req);
  assign mem_addr_o = req_addr_q;

  // stale or branch-cycle responses are completed but never pushed
  assign push_o           = ack_seen && !drop_q && !branch_i;
  assign push_data_o.data = mem_rdata_i;
  assign push_data_o.addr = req_addr_q;

  ////////////////////
  // handshake phases
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= port_idle;
      drop_q       <= 1'b0;
      fetch_addr_q <= '0;
    end else begin
      case (state_q)
        port_idle: begin
          if (start_req) begin
            state_q <= port_req;
          end
        end
        port_req: begin
          // phase 3, drop req once ack is seen
          if (mem_ack_i) begin
            state_q <= port_release;
          end
        end
        port_release: begin
          // phase 4, wait for return to zero
          if (!mem_ack_i) begin
            state_q <= port_idle;
          end
        end
        default: state_q <= port_idle;
      endcase

      // mark the open transaction stale on a branch
      if (ack_seen) begin
        drop_q <= 1'b0;
      end else if (branch_i && (state_q == port_req)) begin
        drop_q <= 1'b1;
      end

      // next word to fetch, branch wins over the advance
      if (branch_i) begin
        fetch_addr_q <= {branch_addr_i[fetch_pkg::xlen-1:2], 2'b00};
      end else if (push_o) begin
        fetch_addr_q <= fetch_addr_q + 4;
      end
    end
  end

  // address held stable while req is high
  always_ff @(posedge clk) begin
    if (start_req) begin
      req_addr_q <= fetch_addr_q;
    end
  end

  // req only falls after the memory has acknowledged
  a_req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(mem_req_o) |-> $past(mem_ack_i));

endmodule

// ==== verilog/fetch_fifo.sv ====
////////////////////
// prefetch FIFO
// circular buffer for any packed payload, single cycle flush
////////////////////

`timescale 1ns/1ps

module fetch_fifo #(
  parameter type         payload_t = logic [fetch_pkg::xlen-1:0],
  parameter int unsigned depth     = fetch_pkg::fifo_depth
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     not_empty_o,
  output logic     slot_free_o
);

  typedef logic [$clog2(depth)-1:0]   ptr_t;
  typedef logic [$clog2(depth+1)-1:0] count_t;

  payload_t mem_q [depth];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  count_t   count_q;
  logic     do_push;
  logic     do_pop;

  // flush discards anything arriving in the same cycle
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !flush_i;

  assign head_o      = mem_q[rd_ptr_q];
  assign not_empty_o = (count_q != '0);
  // keep one slot back for the response still in flight
  assign slot_free_o = (count_q < count_t'(depth - 1));

  ////////////////////
  // pointers and count
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // the port's slot reservation must keep the buffer from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> (count_q < count_t'(depth)));
  // the aligner only pops a word it has been shown
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> (count_q != '0));

endmodule

// ==== verilog/instr_aligner.sv ====
////////////////////
// instruction aligner
// splits fetch words into 32-bit and compressed instructions with their pc
////////////////////

`timescale 1ns/1ps

module instr_aligner (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       branch_i,
  input  logic [fetch_pkg::xlen-1:0] branch_addr_i,
  input  fetch_pkg::fetch_word_t     word_i,
  input  logic                       word_valid_i,
  output logic                       pop_o,
  output logic                       instr_valid_o,
  output fetch_pkg::instr_t          instr_o,
  input  logic                       instr_ready_i
);

  fetch_pkg::align_state_e    state_q;
  fetch_pkg::align_state_e    state_d;
  logic [fetch_pkg::xlen-1:0] pc_q;
  logic [fetch_pkg::xlen-1:0] pc_d;
  logic [fetch_pkg::xlen-1:0] word_pc;
  // upper halfword of the last consumed word
  logic [15:0]                held_q;
  logic [15:0]                lo_half;
  logic [15:0]                hi_half;
  logic                       offer;
  logic                       use_word;
  logic                       load_held;
  logic                       skip;
  logic                       step;

  assign lo_half = word_i.data[15:0];
  assign hi_half = word_i.data[31:16];

  ////////////////////
  // next state and output
  ////////////////////

  always_comb begin
    state_d            = state_q;
    pc_d               = pc_q;
    offer              = 1'b0;
    use_word           = 1'b0;
    load_held          = 1'b0;
    skip               = 1'b0;
    instr_o.instr      = word_i.data;
    instr_o.compressed = 1'b0;
    instr_o.pc         = pc_q;

    case (state_q)
      fetch_pkg::aligned32: begin
        // instruction starts at the low half of the head word
        offer    = word_valid_i;
        use_word = 1'b1;
        if (lo_half[1:0] == 2'b11) begin
          pc_d = pc_q + 4;
        end else begin
          // compressed, keep the upper half for later
          instr_o.instr      = {16'b0, lo_half};
          instr_o.compressed = 1'b1;
          pc_d               = pc_q + 2;
          load_held          = 1'b1;
          state_d            = (hi_half[1:0] == 2'b11) ? fetch_pkg::aligned16
                                                       : fetch_pkg::misaligned16;
        end
      end

      fetch_pkg::aligned16, fetch_pkg::misaligned32: begin
        // held half opens a 32-bit instruction across the word boundary
        // both states wait for the next word
        offer         = word_valid_i;
        use_word      = 1'b1;
        instr_o.instr = {lo_half, held_q};
        pc_d          = pc_q + 4;
        load_held     = 1'b1;
        state_d       = (hi_half[1:0] == 2'b11) ? fetch_pkg::misaligned32
                                                : fetch_pkg::misaligned16;
      end

      fetch_pkg::misaligned16: begin
        // held compressed instruction, no word needed
        offer              = 1'b1;
        instr_o.instr      = {16'b0, held_q};
        instr_o.compressed = 1'b1;
        pc_d               = pc_q + 2;
        state_d            = fetch_pkg::aligned32;
      end

      fetch_pkg::branch_misaligned: begin
        // target is the upper half, the low half is thrown away
        use_word = 1'b1;
        if (hi_half[1:0] == 2'b11) begin
          // only half of the instruction here, hold it and wait
          skip      = word_valid_i;
          load_held = 1'b1;
          state_d   = fetch_pkg::misaligned32;
        end else begin
          offer              = word_valid_i;
          instr_o.instr      = {16'b0, hi_half};
          instr_o.compressed = 1'b1;
          pc_d               = pc_q + 2;
          state_d            = fetch_pkg::aligned32;
        end
      end

      default: state_d = fetch_pkg::aligned32;
    endcase
  end

  // branch cycle never offers anything
  assign instr_valid_o = offer && !branch_i;
  // ready low freezes the aligner, skip included
  assign step          = !branch_i && instr_ready_i && (offer || skip);
  assign pop_o         = step && use_word;

  ////////////////////
  // state, pc and held half
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::aligned32;
      pc_q    <= '0;
    end else if (branch_i) begin
      state_q <= branch_addr_i[1] ? fetch_pkg::branch_misaligned : fetch_pkg::aligned32;
      pc_q    <= branch_addr_i;
    end else if (step) begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  always_ff @(posedge clk) begin
    if (step && load_held) begin
      held_q <= hi_half;
    end
  end

  // address of the word the head should hold
  // pc points at the held half in the crossing and stored states
  assign word_pc = ((state_q == fetch_pkg::aligned32) ||
                    (state_q == fetch_pkg::branch_misaligned)) ? pc_q : pc_q + 2;

  // FIFO flush and dropped response keep the output quiet after a branch
  a_branch_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |=> !instr_valid_o);

  // the port delivers words in pc order, stale words never reach the head
  a_word_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    (word_valid_i && !branch_i) |->
      (word_i.addr[fetch_pkg::xlen-1:2] == word_pc[fetch_pkg::xlen-1:2]));

endmodule

// ==== verilog/fetch_top.sv ====
////////////////////
// fetch front end top
// memory port, prefetch FIFO and aligner
////////////////////

`timescale 1ns/1ps

module fetch_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       branch_i,
  input  logic [fetch_pkg::xlen-1:0] branch_addr_i,
  output logic                       mem_req_o,
  output logic [fetch_pkg::xlen-1:0] mem_addr_o,
  input  logic                       mem_ack_i,
  input  logic [fetch_pkg::xlen-1:0] mem_rdata_i,
  output logic                       instr_valid_o,
  output fetch_pkg::instr_t          instr_o,
  input  logic                       instr_ready_i
);

  // port to FIFO
  fetch_pkg::fetch_word_t push_data;
  logic                   push;
  logic                   slot_free;
  // FIFO to aligner
  fetch_pkg::fetch_word_t head;
  logic                   not_empty;
  logic                   pop;

  fetch_mem_port port_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .slot_free_i   (slot_free),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i),
    .push_o        (push),
    .push_data_o   (push_data)
  );

  // branch flushes the prefetched words
  fetch_fifo #(
    .payload_t (fetch_pkg::fetch_word_t),
    .depth     (fetch_pkg::fifo_depth)
  ) fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .head_o      (head),
    .not_empty_o (not_empty),
    .slot_free_o (slot_free)
  );

  instr_aligner aligner_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .word_i        (head),
    .word_valid_i  (not_empty),
    .pop_o         (pop),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_ready_i (instr_ready_i)
  );

endmodule

// ==== verif/fetch_checker.sv ====
////////////////////
// fetch front end checker
// instruction stream model, per test comparison and report
////////////////////

`timescale 1ns/1ps

module fetch_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  int                         test_id_i,
  input  logic                       branch_i,
  input  logic [fetch_pkg::xlen-1:0] branch_addr_i,
  input  logic                       instr_valid_i,
  input  fetch_pkg::instr_t          instr_i,
  input  logic                       instr_ready_i,
  output int                         transfers_o,
  output int                         checks_o,
  output int                         errors_o
);

  int                         cur_test;
  int                         test_errors;
  // pc of the next expected instruction
  logic [fetch_pkg::xlen-1:0] model_pc;
  // offer not taken last cycle, must be held
  logic                       held_valid;
  fetch_pkg::instr_t          held_instr;

  initial begin
    cur_test    = 0;
    test_errors = 0;
    transfers_o = 0;
    checks_o    = 0;
    errors_o    = 0;
    model_pc    = '0;
    held_valid  = 1'b0;
  end

  // instruction that starts at halfword pc of the image
  function automatic fetch_pkg::instr_t expect_at(input logic [fetch_pkg::xlen-1:0] pc);
    fetch_pkg::instr_t e;
    logic [7:0]        h;
    logic [7:0]        h_next;
    logic [15:0]       lo;
    h      = pc[8:1];
    h_next = h + 8'd1;
    lo     = fetch_tb.image[h];
    e.pc   = pc;
    if (lo[1:0] == 2'b11) begin
      e.instr      = {fetch_tb.image[h_next], lo};
      e.compressed = 1'b0;
    end else begin
      e.instr      = {16'h0000, lo};
      e.compressed = 1'b1;
    end
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("error test %0d %s: got %h expected %h", cur_test, name, got, want);
      errors_o++;
      test_errors++;
    end
  endtask

  task automatic plain_error(input string what);
    $display("test %0d failed at %0t: %s", cur_test, $time, what);
    errors_o++;
    test_errors++;
  endtask

  ////////////////////
  // sampling at the falling edge
  ////////////////////

  always @(negedge clk) begin
    fetch_pkg::instr_t want;
    if (rst_n) begin
      if (test_id_i != cur_test) begin
        if (cur_test != 0) begin
          $display("test %0d done: %0d instructions, %0d errors",
                   cur_test, transfers_o, test_errors);
        end
        cur_test    = test_id_i;
        transfers_o = 0;
        test_errors = 0;
      end
      if (branch_i) begin
        if (instr_valid_i) begin
          plain_error("instruction offered in a branch cycle");
        end
        // stream restarts at the target
        model_pc   = branch_addr_i;
        held_valid = 1'b0;
      end else begin
        if (held_valid && !(instr_valid_i && (instr_i === held_instr))) begin
          plain_error("offered instruction dropped or changed before transfer");
        end
        held_valid = instr_valid_i && !instr_ready_i;
        held_instr = instr_i;
        if (instr_valid_i && instr_ready_i) begin
          want = expect_at(model_pc);
          compare_field("instr_o.instr", instr_i.instr, want.instr);
          compare_field("instr_o.compressed", 32'(instr_i.compressed), 32'(want.compressed));
          compare_field("instr_o.pc", instr_i.pc, want.pc);
          model_pc = model_pc + (want.compressed ? 32'd2 : 32'd4);
          transfers_o++;
          checks_o++;
        end
      end
    end
  end

endmodule

// ==== verif/fetch_tb.sv ====
////////////////////
// fetch front end testbench
// random programs, memory responder, branch and ready stimulus
////////////////////

`timescale 1ns/1ps

module fetch_tb;

  localparam int n_tests  = 5;
  // instructions checked per test
  localparam int test_len = 200;
  // 40 cycles per expected instruction, plus reset
  localparam int limit_cycles = n_tests * test_len * 40 + 10;

  logic                       clk;
  logic                       rst_n;
  logic                       branch;
  logic [fetch_pkg::xlen-1:0] branch_addr;
  logic                       mem_req;
  logic [fetch_pkg::xlen-1:0] mem_addr;
  logic                       mem_ack;
  logic [fetch_pkg::xlen-1:0] mem_rdata;
  logic                       instr_valid;
  fetch_pkg::instr_t          instr;
  logic                       instr_ready;
  int                         test_id;
  int                         transfers;
  int                         checks;
  int                         errors;
  int                         mem_errors;

  // program image in halfwords, the checker reads it too
  logic [15:0] image [256];
  logic [15:0] lfsr_q;
  // memory responder
  logic        req_prev;
  logic        resp_busy;
  int          wait_cnt;

  fetch_top fetch_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .mem_req_o     (mem_req),
    .mem_addr_o    (mem_addr),
    .mem_ack_i     (mem_ack),
    .mem_rdata_i   (mem_rdata),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .instr_ready_i (instr_ready)
  );

  fetch_checker fetch_checker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .test_id_i     (test_id),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .instr_ready_i (instr_ready),
    .transfers_o   (transfers),
    .checks_o      (checks),
    .errors_o      (errors)
  );

  // x^16 + x^14 + x^13 + x^11 + 1, shifts right
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  // one LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // kind 0 all 32-bit, 1 all compressed, 2 random mix
  task automatic fill_image(input int kind);
    logic [31:0] r;
    for (int h = 0; h < 256; h++) begin
      take_bits(16, r);
      case (kind)
        0:       image[h] = (h % 2 == 0) ? {r[15:2], 2'b11} : r[15:0];
        1:       image[h] = {r[15:2], 1'b0, r[0]};
        default: image[h] = r[15:0];
      endcase
    end
  endtask

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////
  // memory responder
  ////////////////////

  always @(posedge clk) begin
    logic [31:0] r;
    logic [7:0]  idx;
    #2;
    if (rst_n) begin
      if (mem_req && !req_prev && mem_ack) begin
        $display("memory protocol: req rose while ack was still high at %0t", $time);
        mem_errors++;
      end
      if (mem_req && (mem_addr[1:0] != 2'b00)) begin
        $display("error mem_addr_o: %h is not word aligned", mem_addr);
        mem_errors++;
      end
      if (mem_ack) begin
        // phase 4, release after req has fallen
        if (!mem_req) begin
          mem_ack = 1'b0;
        end
      end else if (mem_req) begin
        // new request, pick a latency of 0 to 3 cycles
        if (!resp_busy) begin
          take_bits(2, r);
          wait_cnt  = int'(r[1:0]);
          resp_busy = 1'b1;
        end
        if (wait_cnt == 0) begin
          idx       = {mem_addr[8:2], 1'b0};
          mem_rdata = {image[idx + 8'd1], image[idx]};
          mem_ack   = 1'b1;
          resp_busy = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
      req_prev = mem_req;
    end
  end

  ////////////////////
  // test sequence
  ////////////////////

  task automatic run_test(input int t);
    logic [31:0] r;
    // new program, then restart at 0
    fill_image((t == 1) ? 0 : ((t == 2) ? 1 : 2));
    instr_ready = 1'b0;
    test_id     = t;
    branch      = 1'b1;
    branch_addr = '0;
    @(posedge clk);
    #1;
    branch      = 1'b0;
    instr_ready = 1'b1;
    while (transfers < test_len) begin
      branch = 1'b0;
      // random branches to any halfword of the image
      if (t == 4) begin
        take_bits(4, r);
        if (r[3:0] == 4'd0) begin
          take_bits(8, r);
          branch      = 1'b1;
          branch_addr = {23'b0, r[7:0], 1'b0};
        end
      end
      // decode stalls a quarter of the time
      if (t == 5) begin
        take_bits(2, r);
        instr_ready = (r[1:0] != 2'b00);
      end
      @(posedge clk);
      #1;
    end
    branch = 1'b0;
  endtask

  initial begin
    lfsr_q      = 16'd98;
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    mem_ack     = 1'b0;
    mem_rdata   = '0;
    instr_ready = 1'b0;
    test_id     = 0;
    mem_errors  = 0;
    req_prev    = 1'b0;
    resp_busy   = 1'b0;
    wait_cnt    = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int t = 1; t <= n_tests; t++) begin
      run_test(t);
    end
    // close the last test
    instr_ready = 1'b0;
    test_id     = 0;
    @(posedge clk);
    #1;
    $display("summary: %0d tests, %0d instructions, %0d checker errors, %0d memory errors",
             n_tests, checks, errors, mem_errors);
    if (errors == 0 && mem_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(limit_cycles * 10);
    $display("timeout: test %0d received only %0d of %0d instructions in %0d cycles",
             test_id, transfers, test_len, limit_cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== project.f ====
verilog/fetch_pkg.sv
verilog/fetch_mem_port.sv
verilog/fetch_fifo.sv
verilog/instr_aligner.sv
verilog/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv
